//--- hw/axi_pkg.sv
`default_nettype none

package axi_pkg;

    localparam int ID_W   = 4;
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    localparam logic [1:0] RESP_OKAY  = 2'b00;
    localparam logic [1:0] BURST_INCR = 2'b01;
    localparam logic [2:0] SIZE_4B    = 3'b010;

    // len is kept at the full 8 bits so both address channels match.
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
        logic [1:0]        lock;
        logic [3:0]        cache;
        logic [2:0]        prot;
    } axi_ar_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
        logic [1:0]        lock;
        logic [3:0]        cache;
        logic [2:0]        prot;
    } axi_aw_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } axi_r_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        logic [1:0]      resp;
    } axi_b_t;

endpackage

`default_nettype wire

//--- hw/ram_pkg.sv
`default_nettype none

package ram_pkg;

    // one bank entry per 32-bit word, 4 KiB in total.
    localparam int DEPTH      = 1024;
    localparam int IDX_W      = 10;
    localparam int IDX_LSB    = 2;
    localparam int FIFO_DEPTH = 4;

    typedef struct packed {
        logic [7:0] byte3;
        logic [7:0] byte2;
        logic [7:0] byte1;
        logic [7:0] byte0;
    } ram_bytes_t;

    // the slave works on byte lanes, everything else on whole words.
    typedef union packed {
        logic [axi_pkg::DATA_W-1:0] word;
        ram_bytes_t                 bytes;
    } ram_word_u;

    typedef struct packed {
        logic                       write;
        logic [axi_pkg::ADDR_W-1:0] addr;
        ram_word_u                  data;
        logic [axi_pkg::STRB_W-1:0] strb;
    } host_cmd_t;

    // data is zero for a write result.
    typedef struct packed {
        logic                     write;
        logic [axi_pkg::ID_W-1:0] id;
        logic [1:0]               resp;
        ram_word_u                data;
    } host_result_t;

endpackage

`default_nettype wire

//--- hw/axi_cmd_master.sv
`timescale 1ns/100ps
`default_nettype none

module axi_cmd_master (
    input  logic                  aclk,
    input  logic                  rst_n,
    input  ram_pkg::host_cmd_t    cmd,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    output axi_pkg::axi_ar_t      ar,
    output logic                  arvalid,
    input  logic                  arready,
    output axi_pkg::axi_aw_t      aw,
    output logic                  awvalid,
    input  logic                  awready,
    output axi_pkg::axi_w_t       w,
    output logic                  wvalid,
    input  logic                  wready,
    input  axi_pkg::axi_r_t       r,
    input  logic                  rvalid,
    output logic                  rready,
    input  axi_pkg::axi_b_t       b,
    input  logic                  bvalid,
    output logic                  bready,
    output ram_pkg::host_result_t result,
    output logic                  push,
    input  logic                  full
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_ADDR,
        ST_RD_WAIT,
        ST_WR_REQ,
        ST_WR_WAIT
    } state_t;

    state_t                   state;
    ram_pkg::host_cmd_t       cmd_q;
    logic [axi_pkg::ID_W-1:0] id_cnt;
    logic                     aw_done;
    logic                     w_done;
    logic                     aw_fire;
    logic                     w_fire;
    logic                     wr_issued;
    logic                     r_fire;
    logic                     b_fire;

    assign cmd_ready = (state == ST_IDLE);

    // single beat, full word, incrementing burst.
    assign ar.id    = id_cnt;
    assign ar.addr  = cmd_q.addr;
    assign ar.len   = 8'd0;
    assign ar.size  = axi_pkg::SIZE_4B;
    assign ar.burst = axi_pkg::BURST_INCR;
    assign ar.lock  = 2'b00;
    assign ar.cache = 4'b0000;
    assign ar.prot  = 3'b000;

    assign aw.id    = id_cnt;
    assign aw.addr  = cmd_q.addr;
    assign aw.len   = 8'd0;
    assign aw.size  = axi_pkg::SIZE_4B;
    assign aw.burst = axi_pkg::BURST_INCR;
    assign aw.lock  = 2'b00;
    assign aw.cache = 4'b0000;
    assign aw.prot  = 3'b000;

    assign w.id   = id_cnt;
    assign w.data = cmd_q.data.word;
    assign w.strb = cmd_q.strb;
    assign w.last = 1'b1;

    assign arvalid = (state == ST_RD_ADDR);
    assign awvalid = (state == ST_WR_REQ) && !aw_done;
    assign wvalid  = (state == ST_WR_REQ) && !w_done;

    assign aw_fire   = awvalid && awready;
    assign w_fire    = wvalid && wready;
    assign wr_issued = (aw_done || aw_fire) && (w_done || w_fire);

    // a response waits in the slave until the fifo has room.
    assign rready = (state == ST_RD_WAIT) && !full;
    assign bready = (state == ST_WR_WAIT) && !full;
    assign r_fire = rvalid && rready;
    assign b_fire = bvalid && bready;
    assign push   = r_fire || b_fire;

    always_comb begin
        result.write = (state == ST_WR_WAIT);
        if (state == ST_WR_WAIT) begin
            result.id        = b.id;
            result.resp      = b.resp;
            result.data.word = '0;
        end else begin
            result.id        = r.id;
            result.resp      = r.resp;
            result.data.word = r.data;
        end
    end

    always_ff @(posedge aclk) begin
        if (cmd_valid && cmd_ready) begin
            cmd_q <= cmd;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            id_cnt  <= '0;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    aw_done <= 1'b0;
                    w_done  <= 1'b0;
                    if (cmd_valid) begin
                        state <= cmd.write ? ST_WR_REQ : ST_RD_ADDR;
                    end
                end
                ST_RD_ADDR: begin
                    if (arready) begin
                        state <= ST_RD_WAIT;
                    end
                end
                ST_WR_REQ: begin
                    // each channel drops its valid once accepted.
                    if (aw_fire) begin
                        aw_done <= 1'b1;
                    end
                    if (w_fire) begin
                        w_done <= 1'b1;
                    end
                    if (wr_issued) begin
                        state <= ST_WR_WAIT;
                    end
                end
                ST_RD_WAIT, ST_WR_WAIT: begin
                    if (push) begin
                        state  <= ST_IDLE;
                        id_cnt <= id_cnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/axi_ram_slave.sv
`timescale 1ns/100ps
`default_nettype none

module axi_ram_slave (
    input  logic             aclk,
    input  logic             rst_n,
    input  axi_pkg::axi_ar_t ar,
    input  logic             arvalid,
    output logic             arready,
    output axi_pkg::axi_r_t  r,
    output logic             rvalid,
    input  logic             rready,
    input  axi_pkg::axi_aw_t aw,
    input  logic             awvalid,
    output logic             awready,
    input  axi_pkg::axi_w_t  w,
    input  logic             wvalid,
    output logic             wready,
    output axi_pkg::axi_b_t  b,
    output logic             bvalid,
    input  logic             bready
);

    logic [7:0] bank0 [ram_pkg::DEPTH];
    logic [7:0] bank1 [ram_pkg::DEPTH];
    logic [7:0] bank2 [ram_pkg::DEPTH];
    logic [7:0] bank3 [ram_pkg::DEPTH];

    logic [ram_pkg::IDX_W-1:0] rd_idx;
    logic [ram_pkg::IDX_W-1:0] wr_idx;
    ram_pkg::ram_word_u        wr_word;
    ram_pkg::ram_word_u        rd_word;
    logic [axi_pkg::ID_W-1:0]  rid_q;
    logic [axi_pkg::ID_W-1:0]  bid_q;
    logic                      ar_fire;
    logic                      wr_fire;

    // higher address bits alias, byte offset is ignored.
    assign rd_idx  = ar.addr[ram_pkg::IDX_LSB +: ram_pkg::IDX_W];
    assign wr_idx  = aw.addr[ram_pkg::IDX_LSB +: ram_pkg::IDX_W];
    assign wr_word = w.data;

    // one outstanding response per direction.
    assign arready = !rvalid;
    assign awready = !bvalid;
    assign wready  = !bvalid;

    assign ar_fire = arvalid && arready;
    assign wr_fire = awvalid && awready && wvalid && wready;

    always_ff @(posedge aclk) begin
        if (wr_fire) begin
            if (w.strb[3]) begin
                bank3[wr_idx] <= wr_word.bytes.byte3;
            end
            if (w.strb[2]) begin
                bank2[wr_idx] <= wr_word.bytes.byte2;
            end
            if (w.strb[1]) begin
                bank1[wr_idx] <= wr_word.bytes.byte1;
            end
            if (w.strb[0]) begin
                bank0[wr_idx] <= wr_word.bytes.byte0;
            end
        end
    end

    // read word and ids are captured only on a transfer and held until taken.
    always_ff @(posedge aclk) begin
        if (ar_fire) begin
            rd_word.bytes.byte3 <= bank3[rd_idx];
            rd_word.bytes.byte2 <= bank2[rd_idx];
            rd_word.bytes.byte1 <= bank1[rd_idx];
            rd_word.bytes.byte0 <= bank0[rd_idx];
            rid_q               <= ar.id;
        end
        if (wr_fire) begin
            bid_q <= aw.id;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            if (ar_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // every beat is the last one of a single-beat burst.
    assign r.id   = rid_q;
    assign r.data = rd_word.word;
    assign r.resp = axi_pkg::RESP_OKAY;
    assign r.last = 1'b1;

    assign b.id   = bid_q;
    assign b.resp = axi_pkg::RESP_OKAY;

endmodule

`default_nettype wire

//--- hw/result_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module result_fifo (
    input  logic                  aclk,
    input  logic                  rst_n,
    input  ram_pkg::host_result_t in_data,
    input  logic                  push,
    output logic                  full,
    output ram_pkg::host_result_t out_data,
    output logic                  out_valid,
    input  logic                  pop_ready
);

    ram_pkg::host_result_t mem [ram_pkg::FIFO_DEPTH];

    logic [$clog2(ram_pkg::FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(ram_pkg::FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(ram_pkg::FIFO_DEPTH+1)-1:0] count;
    logic pop;

    assign full      = (count == ram_pkg::FIFO_DEPTH);
    assign out_valid = (count != 0);
    assign out_data  = mem[rd_ptr];
    assign pop       = out_valid && pop_ready;

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // pointers wrap naturally since the depth is a power of two.
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/ram_subsystem_top.sv
`timescale 1ns/100ps
`default_nettype none

module ram_subsystem_top (
    input  logic                  aclk,
    input  logic                  rst_n,
    input  ram_pkg::host_cmd_t    cmd,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    output ram_pkg::host_result_t result,
    output logic                  result_valid,
    input  logic                  result_ready
);

    axi_pkg::axi_ar_t ar;
    axi_pkg::axi_aw_t aw;
    axi_pkg::axi_w_t  w;
    axi_pkg::axi_r_t  r;
    axi_pkg::axi_b_t  b;
    logic             arvalid;
    logic             arready;
    logic             awvalid;
    logic             awready;
    logic             wvalid;
    logic             wready;
    logic             rvalid;
    logic             rready;
    logic             bvalid;
    logic             bready;

    // completed results on their way to the fifo.
    ram_pkg::host_result_t fifo_in;
    logic                  fifo_push;
    logic                  fifo_full;

    axi_cmd_master u_master (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .aw        (aw),
        .awvalid   (awvalid),
        .awready   (awready),
        .w         (w),
        .wvalid    (wvalid),
        .wready    (wready),
        .r         (r),
        .rvalid    (rvalid),
        .rready    (rready),
        .b         (b),
        .bvalid    (bvalid),
        .bready    (bready),
        .result    (fifo_in),
        .push      (fifo_push),
        .full      (fifo_full)
    );

    axi_ram_slave u_slave (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready),
        .b       (b),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    result_fifo u_fifo (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .in_data   (fifo_in),
        .push      (fifo_push),
        .full      (fifo_full),
        .out_data  (result),
        .out_valid (result_valid),
        .pop_ready (result_ready)
    );

endmodule

`default_nettype wire

//--- tests/tb_ram_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ram_subsystem;

    localparam int RAND_OPS = 200;
    localparam int POOL     = 16;
    // commands issued by tests 2 to 6.
    localparam int NUM_CMDS   = 12 + 7 + 6 + 5 + POOL + RAND_OPS;
    localparam int TIMEOUT_NS = NUM_CMDS * 200 + 1000;

    logic                  aclk = 1'b0;
    logic                  rst_n;
    ram_pkg::host_cmd_t    cmd;
    logic                  cmd_valid;
    logic                  cmd_ready;
    ram_pkg::host_result_t result;
    logic                  result_valid;
    logic                  result_ready;

    ram_pkg::ram_word_u    model [ram_pkg::DEPTH];
    ram_pkg::host_result_t exp_q [$];
    int                    errors;
    int                    cmd_count;

    ram_subsystem_top UUT (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready)
    );

    always #2 aclk = ~aclk;

    // inputs move half a nanosecond after the rising edge.
    task automatic next_cycle();
        @(posedge aclk);
        #0.5;
    endtask

    task automatic check_word(input string name, input ram_pkg::ram_word_u exp,
                              input ram_pkg::ram_word_u act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h got %h", name, exp.word, act.word);
        end
    endtask

    task automatic check_result(input string name, input ram_pkg::host_result_t exp,
                                input ram_pkg::host_result_t act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic send_cmd(input logic wr, input logic [31:0] addr,
                            input logic [31:0] data, input logic [3:0] strb);
        while (!cmd_ready) begin
            next_cycle();
        end
        cmd.write     = wr;
        cmd.addr      = addr;
        cmd.data.word = data;
        cmd.strb      = strb;
        cmd_valid     = 1'b1;
        next_cycle();
        cmd_valid = 1'b0;
    endtask

    task automatic get_result(input int stall, output ram_pkg::host_result_t res);
        result_ready = 1'b0;
        repeat (stall) next_cycle();
        result_ready = 1'b1;
        while (!result_valid) begin
            next_cycle();
        end
        res = result;
        next_cycle();
        result_ready = 1'b0;
    endtask

    task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        logic [ram_pkg::IDX_W-1:0] idx;
        ram_pkg::ram_word_u        d;
        idx    = addr[11:2];
        d.word = data;
        if (strb[0]) begin
            model[idx].bytes.byte0 = d.bytes.byte0;
        end
        if (strb[1]) begin
            model[idx].bytes.byte1 = d.bytes.byte1;
        end
        if (strb[2]) begin
            model[idx].bytes.byte2 = d.bytes.byte2;
        end
        if (strb[3]) begin
            model[idx].bytes.byte3 = d.bytes.byte3;
        end
    endtask

    // commands complete in order, so the model is updated at issue time.
    task automatic issue_cmd(input logic wr, input logic [31:0] addr,
                             input logic [31:0] data, input logic [3:0] strb);
        ram_pkg::host_result_t exp;
        exp.write = wr;
        exp.id    = 4'(cmd_count % 16);
        exp.resp  = 2'b00;
        if (wr) begin
            exp.data.word = '0;
            model_write(addr, data, strb);
        end else begin
            exp.data = model[addr[11:2]];
        end
        exp_q.push_back(exp);
        cmd_count++;
        send_cmd(wr, addr, data, strb);
    endtask

    task automatic take_result(input int stall, output ram_pkg::host_result_t res);
        ram_pkg::host_result_t exp;
        get_result(stall, res);
        exp = exp_q.pop_front();
        check_result("result", exp, res);
    endtask

    task automatic test_reset();
        check_bit("cmd_ready", 1'b1, cmd_ready);
        check_bit("result_valid", 1'b0, result_valid);
    endtask

    task automatic test_full_words();
        logic [31:0]           addrs [6] = '{32'h000, 32'h004, 32'h3fc, 32'ha40, 32'hffc, 32'h7e0};
        ram_pkg::ram_word_u    wdata [6];
        ram_pkg::host_result_t res;
        foreach (addrs[i]) begin
            wdata[i].word = $urandom;
            issue_cmd(1'b1, addrs[i], wdata[i].word, 4'hf);
            take_result(0, res);
        end
        foreach (addrs[i]) begin
            issue_cmd(1'b0, addrs[i], 32'h0, 4'h0);
            take_result(0, res);
            check_word("read data", wdata[i], res.data);
        end
    endtask

    task automatic test_partial_strobes();
        logic [3:0]            strbs [3] = '{4'b0101, 4'b1000, 4'b0010};
        logic [31:0]           datas [3] = '{32'haabbccdd, 32'h55667788, 32'h0000ee00};
        logic [31:0]           merged [3] = '{32'h11bb33dd, 32'h55bb33dd, 32'h55bbeedd};
        ram_pkg::ram_word_u    exp;
        ram_pkg::host_result_t res;
        issue_cmd(1'b1, 32'h120, 32'h11223344, 4'hf);
        take_result(0, res);
        foreach (strbs[i]) begin
            issue_cmd(1'b1, 32'h120, datas[i], strbs[i]);
            take_result(0, res);
            issue_cmd(1'b0, 32'h120, 32'h0, 4'h0);
            take_result(0, res);
            exp.word = merged[i];
            check_word("merged data", exp, res.data);
        end
    endtask

    task automatic test_aliasing();
        logic [31:0]           aliases [3] = '{32'h0000_0103, 32'h0000_1100, 32'hffff_f102};
        ram_pkg::ram_word_u    exp;
        ram_pkg::host_result_t res;
        issue_cmd(1'b1, 32'h100, 32'hcafe_f00d, 4'hf);
        take_result(0, res);
        exp.word = 32'hcafe_f00d;
        foreach (aliases[i]) begin
            issue_cmd(1'b0, aliases[i], 32'h0, 4'h0);
            take_result(0, res);
            check_word("aliased read", exp, res.data);
        end
        issue_cmd(1'b1, 32'habcd_5101, 32'h1357_9bdf, 4'hf);
        take_result(0, res);
        issue_cmd(1'b0, 32'h100, 32'h0, 4'h0);
        take_result(0, res);
        exp.word = 32'h1357_9bdf;
        check_word("aliased write", exp, res.data);
    endtask

    task automatic test_fifo_backpressure();
        logic [31:0]           addrs [5] = '{32'h000, 32'h004, 32'h3fc, 32'ha40, 32'hffc};
        ram_pkg::host_result_t res;
        result_ready = 1'b0;
        foreach (addrs[i]) begin
            issue_cmd(1'b0, addrs[i], 32'h0, 4'h0);
        end
        repeat (4) next_cycle();
        // four results fill the fifo, the fifth stays in the slave.
        check_bit("cmd_ready", 1'b0, cmd_ready);
        check_bit("result_valid", 1'b1, result_valid);
        repeat (5) take_result(0, res);
    endtask

    task automatic test_random();
        ram_pkg::host_result_t res;
        logic [31:0]           addr;
        int                    done;
        int                    batch;
        for (int k = 0; k < POOL; k++) begin
            issue_cmd(1'b1, 32'h800 + k * 4, $urandom, 4'hf);
            take_result(0, res);
        end
        done = 0;
        while (done < RAND_OPS) begin
            batch = 1 + $urandom % 4;
            if (batch > RAND_OPS - done) begin
                batch = RAND_OPS - done;
            end
            for (int j = 0; j < batch; j++) begin
                addr = ($urandom & 32'hffff_f003) | 32'h800 | (($urandom % POOL) << 2);
                issue_cmd(1'($urandom % 2), addr, $urandom, 4'($urandom % 16));
            end
            repeat (batch) take_result($urandom % 4, res);
            done += batch;
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        void'($urandom(32'hd3ec_d955));
        errors       = 0;
        cmd_count    = 0;
        rst_n        = 1'b0;
        cmd          = '0;
        cmd_valid    = 1'b0;
        result_ready = 1'b0;
        repeat (2) @(posedge aclk);
        #0.5;
        rst_n = 1'b1;

        test_reset();
        test_full_words();
        test_partial_strobes();
        test_aliasing();
        test_fifo_backpressure();
        test_random();

        repeat (4) next_cycle();
        check_bit("result_valid", 1'b0, result_valid);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
hw/axi_pkg.sv
hw/ram_pkg.sv
hw/axi_cmd_master.sv
hw/axi_ram_slave.sv
hw/result_fifo.sv
hw/ram_subsystem_top.sv
tests/tb_ram_subsystem.sv

//--- Bender.yml
package:
  name: ram_subsystem

sources:
  - target: any(rtl, simulation, test)
    files:
      - hw/axi_pkg.sv
      - hw/ram_pkg.sv
      - hw/axi_cmd_master.sv
      - hw/axi_ram_slave.sv
      - hw/result_fifo.sv
      - hw/ram_subsystem_top.sv
  - target: test
    files:
      - tests/tb_ram_subsystem.sv
